//--- design/bus_pkg.sv
// bus-side encodings shared by the master and the sram slave
// burst types, response codes and bus widths
package bus_pkg;

	// data path is fixed at one 32-bit word per beat
	localparam int DATA_W = 32;

	// byte address width on both address channels
	localparam int ADDR_W = 32;

	// burst type, encoded as on an AXI bus
	// fixed bursts are never issued, so 2'b00 stays unused
	typedef enum logic [1:0] {
		burst_incr = 2'b01,
		burst_wrap = 2'b10
	} burst_t;

	// response code for read beats and write responses
	// only okay and slave error are produced
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} resp_t;

endpackage

//--- design/fsm_pkg.sv
// request opcodes and controller state encodings
// used by the fetch master and the sram slave FSMs
package fsm_pkg;

	// request port opcode
	typedef enum logic [1:0] {
		op_line   = 2'b00,
		op_stream = 2'b01,
		op_store  = 2'b10
	} req_op_t;

	// slave read side, fetch state waits on the array register
	typedef enum logic [1:0] {
		rd_idle  = 2'b00,
		rd_fetch = 2'b01,
		rd_send  = 2'b10
	} rd_state_t;

	// slave write side
	typedef enum logic [1:0] {
		wr_idle   = 2'b00,
		wr_commit = 2'b01,
		wr_resp   = 2'b10
	} wr_state_t;

	// master, one operation in flight
	typedef enum logic [2:0] {
		m_idle = 3'b000,
		m_ar   = 3'b001,
		m_aw   = 3'b010,
		m_data = 3'b011,
		m_resp = 3'b100
	} mst_state_t;

endpackage

//--- design/line_refill_master.sv
// fetch-side master, turns requests into read bursts or a single write
// read beats and write responses share one beat register toward the outside
`timescale 1ns/1ns

module line_refill_master #(
	parameter int LINE_WORDS = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	// request port
	input  logic                       req_valid,
	output logic                       req_ready,
	input  fsm_pkg::req_op_t           req_op,
	input  logic [bus_pkg::ADDR_W-1:0] req_addr,
	input  logic [7:0]                 req_len,
	input  logic [bus_pkg::DATA_W-1:0] req_wdata,
	input  logic [3:0]                 req_wstrb,
	// beat port
	output logic                       beat_valid,
	input  logic                       beat_ready,
	output logic [bus_pkg::DATA_W-1:0] beat_data,
	output logic                       beat_last,
	output logic                       beat_err,
	// read channels
	output logic                       arvalid,
	input  logic                       arready,
	output logic [bus_pkg::ADDR_W-1:0] araddr,
	output logic [7:0]                 arlen,
	output bus_pkg::burst_t            arburst,
	input  logic                       rvalid,
	output logic                       rready,
	input  logic [bus_pkg::DATA_W-1:0] rdata,
	input  bus_pkg::resp_t             rresp,
	input  logic                       rlast,
	// write channels
	output logic                       awvalid,
	input  logic                       awready,
	output logic [bus_pkg::ADDR_W-1:0] awaddr,
	output logic                       wvalid,
	input  logic                       wready,
	output logic [bus_pkg::DATA_W-1:0] wdata,
	output logic [3:0]                 wstrb,
	input  logic                       bvalid,
	output logic                       bready,
	input  bus_pkg::resp_t             bresp
);

	fsm_pkg::mst_state_t state;

	// latched request, word aligned address
	logic [bus_pkg::ADDR_W-1:0] addr_q;
	logic [7:0]                 len_q;
	bus_pkg::burst_t            burst_q;
	logic [bus_pkg::DATA_W-1:0] wdata_q;
	logic [3:0]                 wstrb_q;

	// one-entry beat register
	logic                       beat_full;
	logic [bus_pkg::DATA_W-1:0] beat_data_q;
	logic                       beat_last_q;
	logic                       beat_err_q;

	logic req_take;
	logic r_take;
	logic b_take;
	logic beat_take;

	assign req_ready = (state == fsm_pkg::m_idle);
	assign req_take  = req_valid && req_ready;

	assign arvalid = (state == fsm_pkg::m_ar);
	assign araddr  = addr_q;
	assign arlen   = len_q;
	assign arburst = burst_q;

	// address and data go out together
	assign awvalid = (state == fsm_pkg::m_aw);
	assign wvalid  = (state == fsm_pkg::m_aw);
	assign awaddr  = addr_q;
	assign wdata   = wdata_q;
	assign wstrb   = wstrb_q;

	// accept from the slave only into an empty beat register
	assign rready = (state == fsm_pkg::m_data) && !beat_full;
	assign bready = (state == fsm_pkg::m_resp) && !beat_full;
	assign r_take = rvalid && rready;
	assign b_take = bvalid && bready;

	assign beat_valid = beat_full;
	assign beat_data  = beat_data_q;
	assign beat_last  = beat_last_q;
	assign beat_err   = beat_err_q;
	assign beat_take  = beat_full && beat_ready;

	// operation FSM
	// back to idle only once the last beat has left
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fsm_pkg::m_idle;
		end else begin
			case (state)
				fsm_pkg::m_idle: begin
					if (req_take) begin
						if (req_op == fsm_pkg::op_store) begin
							state <= fsm_pkg::m_aw;
						end else begin
							state <= fsm_pkg::m_ar;
						end
					end
				end
				fsm_pkg::m_ar: begin
					if (arready) begin
						state <= fsm_pkg::m_data;
					end
				end
				fsm_pkg::m_aw: begin
					if (awready && wready) begin
						state <= fsm_pkg::m_resp;
					end
				end
				fsm_pkg::m_data, fsm_pkg::m_resp: begin
					if (beat_take && beat_last_q) begin
						state <= fsm_pkg::m_idle;
					end
				end
				default: begin
					state <= fsm_pkg::m_idle;
				end
			endcase
		end
	end

	// request decode
	// line fetch wraps over LINE_WORDS, stream counts up from req_len
	always_ff @(posedge clk) begin
		if (req_take) begin
			addr_q  <= {req_addr[bus_pkg::ADDR_W-1:2], 2'b00};
			wdata_q <= req_wdata;
			wstrb_q <= req_wstrb;
			if (req_op == fsm_pkg::op_line) begin
				len_q   <= 8'(LINE_WORDS - 1);
				burst_q <= bus_pkg::burst_wrap;
			end else begin
				len_q   <= req_len;
				burst_q <= bus_pkg::burst_incr;
			end
		end
	end

	// beat register flag
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_full <= 1'b0;
		end else if (r_take || b_take) begin
			beat_full <= 1'b1;
		end else if (beat_take) begin
			beat_full <= 1'b0;
		end
	end

	// beat payload
	// store completion is a single zero-data beat
	always_ff @(posedge clk) begin
		if (r_take) begin
			beat_data_q <= rdata;
			beat_last_q <= rlast;
			beat_err_q  <= (rresp == bus_pkg::resp_slverr);
		end else if (b_take) begin
			beat_data_q <= '0;
			beat_last_q <= 1'b1;
			beat_err_q  <= (bresp == bus_pkg::resp_slverr);
		end
	end

endmodule

//--- design/mem_subsys_top.sv
// memory subsystem top, fetch master on an sram slave
// read and write channel controllers share one word array
`timescale 1ns/1ns

module mem_subsys_top #(
	parameter int MEM_WORDS  = 1024,
	parameter int LINE_WORDS = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  fsm_pkg::req_op_t           req_op,
	input  logic [bus_pkg::ADDR_W-1:0] req_addr,
	input  logic [7:0]                 req_len,
	input  logic [bus_pkg::DATA_W-1:0] req_wdata,
	input  logic [3:0]                 req_wstrb,
	output logic                       beat_valid,
	input  logic                       beat_ready,
	output logic [bus_pkg::DATA_W-1:0] beat_data,
	output logic                       beat_last,
	output logic                       beat_err
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	// read address and data channels
	logic                       arvalid;
	logic                       arready;
	logic [bus_pkg::ADDR_W-1:0] araddr;
	logic [7:0]                 arlen;
	bus_pkg::burst_t            arburst;
	logic                       rvalid;
	logic                       rready;
	logic [bus_pkg::DATA_W-1:0] rdata;
	bus_pkg::resp_t             rresp;
	logic                       rlast;

	// write address, data and response channels
	logic                       awvalid;
	logic                       awready;
	logic [bus_pkg::ADDR_W-1:0] awaddr;
	logic                       wvalid;
	logic                       wready;
	logic [bus_pkg::DATA_W-1:0] wdata;
	logic [3:0]                 wstrb;
	logic                       bvalid;
	logic                       bready;
	bus_pkg::resp_t             bresp;

	// array ports
	logic                       rd_en;
	logic [IDX_W-1:0]           rd_addr;
	logic [bus_pkg::DATA_W-1:0] rd_data;
	logic                       wr_en;
	logic [IDX_W-1:0]           wr_addr;
	logic [bus_pkg::DATA_W-1:0] wr_data;
	logic [3:0]                 wr_strb;

	line_refill_master #(
		.LINE_WORDS(LINE_WORDS)
	) line_refill_master_inst (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
		.req_addr(req_addr), .req_len(req_len),
		.req_wdata(req_wdata), .req_wstrb(req_wstrb),
		.beat_valid(beat_valid), .beat_ready(beat_ready), .beat_data(beat_data),
		.beat_last(beat_last), .beat_err(beat_err),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.arlen(arlen), .arburst(arburst),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp), .rlast(rlast),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp)
	);

	sram_axi_read #(
		.MEM_WORDS(MEM_WORDS)
	) sram_axi_read_inst (
		.clk(clk), .rst(rst),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.arlen(arlen), .arburst(arburst),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp), .rlast(rlast),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	sram_axi_write #(
		.MEM_WORDS(MEM_WORDS)
	) sram_axi_write_inst (
		.clk(clk), .rst(rst),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb)
	);

	sram_array #(
		.MEM_WORDS(MEM_WORDS)
	) sram_array_inst (
		.clk(clk),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb)
	);

endmodule

//--- design/sram_array.sv
// on-chip word memory with byte-strobed write
// read data is registered and held between reads
`timescale 1ns/1ns

module sram_array #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                         clk,
	input  logic                         rd_en,
	input  logic [$clog2(MEM_WORDS)-1:0] rd_addr,
	output logic [bus_pkg::DATA_W-1:0]   rd_data,
	input  logic                         wr_en,
	input  logic [$clog2(MEM_WORDS)-1:0] wr_addr,
	input  logic [bus_pkg::DATA_W-1:0]   wr_data,
	input  logic [3:0]                   wr_strb
);

	// bytes per word, one strobe bit each
	localparam int BYTES = bus_pkg::DATA_W / 8;

	logic [bus_pkg::DATA_W-1:0] mem [MEM_WORDS];

	// write port
	// only the strobed byte lanes change
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < BYTES; b++) begin
				if (wr_strb[b]) begin
					mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	// read port
	// output register keeps the last word while rd_en is low,
	// which lets the slave hold rdata under back-pressure
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- design/sram_axi_read.sv
// sram slave read channel, burst address generation and range check
// one beat every two cycles, array read in the fetch state
`timescale 1ns/1ns

module sram_axi_read #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         arvalid,
	output logic                         arready,
	input  logic [bus_pkg::ADDR_W-1:0]   araddr,
	input  logic [7:0]                   arlen,
	input  bus_pkg::burst_t              arburst,
	output logic                         rvalid,
	input  logic                         rready,
	output logic [bus_pkg::DATA_W-1:0]   rdata,
	output bus_pkg::resp_t               rresp,
	output logic                         rlast,
	output logic                         rd_en,
	output logic [$clog2(MEM_WORDS)-1:0] rd_addr,
	input  logic [bus_pkg::DATA_W-1:0]   rd_data
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	// full word index, address bits 2 and up
	localparam int WIDX_W = bus_pkg::ADDR_W - 2;

	fsm_pkg::rd_state_t state;

	// latched burst
	logic [WIDX_W-1:0] idx_q;
	logic [7:0]        len_q;
	bus_pkg::burst_t   burst_q;
	// beats already sent
	logic [7:0]        cnt_q;

	logic [WIDX_W-1:0] idx_next;
	logic [WIDX_W-1:0] wrap_mask;
	logic              oob;

	// index past the array end
	assign oob = idx_q >= WIDX_W'(MEM_WORDS);

	// wrap block is len+1 words, len+1 a power of two
	assign wrap_mask = WIDX_W'(len_q);

	always_comb begin
		if (burst_q == bus_pkg::burst_wrap) begin
			// low bits count and wrap, high bits stay on the block base
			idx_next = (idx_q & ~wrap_mask) | ((idx_q + 1'b1) & wrap_mask);
		end else begin
			idx_next = idx_q + 1'b1;
		end
	end

	// channel outputs straight from the state
	assign arready = (state == fsm_pkg::rd_idle);
	assign rvalid  = (state == fsm_pkg::rd_send);
	assign rlast   = rvalid && (cnt_q == len_q);
	assign rresp   = (rvalid && oob) ? bus_pkg::resp_slverr : bus_pkg::resp_okay;
	// out of range reads as zero
	assign rdata   = oob ? '0 : rd_data;

	// array access, skipped for out of range words
	assign rd_en   = (state == fsm_pkg::rd_fetch) && !oob;
	assign rd_addr = idx_q[IDX_W-1:0];

	// control FSM and beat counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fsm_pkg::rd_idle;
			cnt_q <= '0;
		end else begin
			case (state)
				fsm_pkg::rd_idle: begin
					if (arvalid) begin
						cnt_q <= '0;
						state <= fsm_pkg::rd_fetch;
					end
				end
				fsm_pkg::rd_fetch: begin
					state <= fsm_pkg::rd_send;
				end
				fsm_pkg::rd_send: begin
					if (rready) begin
						if (rlast) begin
							state <= fsm_pkg::rd_idle;
						end else begin
							cnt_q <= cnt_q + 8'd1;
							state <= fsm_pkg::rd_fetch;
						end
					end
				end
				default: begin
					state <= fsm_pkg::rd_idle;
				end
			endcase
		end
	end

	// burst registers
	// index steps only when a non-last beat is taken
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			idx_q   <= araddr[bus_pkg::ADDR_W-1:2];
			len_q   <= arlen;
			burst_q <= arburst;
		end else if (rvalid && rready && !rlast) begin
			idx_q <= idx_next;
		end
	end

endmodule

//--- design/sram_axi_write.sv
// sram slave write channel, single-beat write with response
// address and data taken together, committed a cycle later
`timescale 1ns/1ns

module sram_axi_write #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [bus_pkg::ADDR_W-1:0]   awaddr,
	input  logic                         wvalid,
	output logic                         wready,
	input  logic [bus_pkg::DATA_W-1:0]   wdata,
	input  logic [3:0]                   wstrb,
	output logic                         bvalid,
	input  logic                         bready,
	output bus_pkg::resp_t               bresp,
	output logic                         wr_en,
	output logic [$clog2(MEM_WORDS)-1:0] wr_addr,
	output logic [bus_pkg::DATA_W-1:0]   wr_data,
	output logic [3:0]                   wr_strb
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int WIDX_W = bus_pkg::ADDR_W - 2;

	fsm_pkg::wr_state_t state;

	// latched write
	logic [WIDX_W-1:0]          idx_q;
	logic [bus_pkg::DATA_W-1:0] data_q;
	logic [3:0]                 strb_q;

	logic oob;
	logic take;

	assign oob  = idx_q >= WIDX_W'(MEM_WORDS);
	// both channels present and slave idle
	assign take = awvalid && wvalid && awready && wready;

	assign awready = (state == fsm_pkg::wr_idle);
	assign wready  = (state == fsm_pkg::wr_idle);

	// commit cycle, no array write when out of range
	assign wr_en   = (state == fsm_pkg::wr_commit) && !oob;
	assign wr_addr = idx_q[IDX_W-1:0];
	assign wr_data = data_q;
	assign wr_strb = strb_q;

	assign bvalid = (state == fsm_pkg::wr_resp);
	assign bresp  = (bvalid && oob) ? bus_pkg::resp_slverr : bus_pkg::resp_okay;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fsm_pkg::wr_idle;
		end else begin
			case (state)
				fsm_pkg::wr_idle: begin
					if (take) begin
						state <= fsm_pkg::wr_commit;
					end
				end
				fsm_pkg::wr_commit: begin
					state <= fsm_pkg::wr_resp;
				end
				fsm_pkg::wr_resp: begin
					// response held until taken
					if (bready) begin
						state <= fsm_pkg::wr_idle;
					end
				end
				default: begin
					state <= fsm_pkg::wr_idle;
				end
			endcase
		end
	end

	// write payload
	always_ff @(posedge clk) begin
		if (take) begin
			idx_q  <= awaddr[bus_pkg::ADDR_W-1:2];
			data_q <= wdata;
			strb_q <= wstrb;
		end
	end

endmodule

//--- mem_subsys.f
design/bus_pkg.sv
design/fsm_pkg.sv
design/sram_array.sv
design/sram_axi_read.sv
design/sram_axi_write.sv
design/line_refill_master.sv
design/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir
bin=sim_mem_subsys

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing -f mem_subsys.f --top-module tb_mem_subsys \
	--Mdir "$obj" -o "$bin"
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

"./$obj/$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log"; then
	echo "failure reported in $log"
	exit 1
fi

echo "no failure reported in $log"
exit 0

//--- verif/tb_mem_subsys.sv
// testbench for the memory subsystem top
// LFSR stimulus, shadow memory, reference model, beat checker and watchdog
`timescale 1ns/1ns

module tb_mem_subsys;

	localparam int MEM_WORDS  = 1024;
	localparam int LINE_WORDS = 4;
	localparam int IDX_W      = $clog2(MEM_WORDS);
	// words preloaded by full stores, in-range reads stay below this
	localparam int FILL_WORDS = 256;
	localparam int N_STORE    = 24;
	localparam int N_LINE     = 16;
	localparam int N_STREAM   = 16;
	localparam int N_OOB      = 4;
	localparam int N_BP       = 32;
	// store plus readback per store round, four ops per out of range round
	localparam int N_OPS = FILL_WORDS + 2 * N_STORE + N_LINE + N_STREAM + 1
		+ 4 * N_OOB + N_BP;
	localparam int MAX_BEATS    = 256;
	localparam int LIMIT_CYCLES = N_OPS * (MAX_BEATS * 4 + 10);

	logic                       clk;
	logic                       rst;
	logic                       req_valid;
	logic                       req_ready;
	fsm_pkg::req_op_t           req_op;
	logic [bus_pkg::ADDR_W-1:0] req_addr;
	logic [7:0]                 req_len;
	logic [bus_pkg::DATA_W-1:0] req_wdata;
	logic [3:0]                 req_wstrb;
	logic                       beat_valid;
	logic                       beat_ready;
	logic [bus_pkg::DATA_W-1:0] beat_data;
	logic                       beat_last;
	logic                       beat_err;

	// expected memory contents
	logic [31:0] shadow [MEM_WORDS];
	logic [15:0] stim_lfsr;
	logic [15:0] ready_lfsr;
	logic        bp_on = 1'b0;

	// operation in flight, owned by the driver
	fsm_pkg::req_op_t cur_op;
	logic [31:0]      cur_addr;
	logic [7:0]       cur_len;
	int               ops_issued = 0;

	// monitor side
	int          ops_done = 0;
	int          beat_no = 0;
	int          errors = 0;
	int          checks = 0;
	logic [31:0] exp_idx;
	logic [31:0] exp_data;
	logic        exp_err;
	logic        exp_last;

	mem_subsys_top #(
		.MEM_WORDS(MEM_WORDS),
		.LINE_WORDS(LINE_WORDS)
	) mem_subsys_top_inst (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
		.req_addr(req_addr), .req_len(req_len),
		.req_wdata(req_wdata), .req_wstrb(req_wstrb),
		.beat_valid(beat_valid), .beat_ready(beat_ready), .beat_data(beat_data),
		.beat_last(beat_last), .beat_err(beat_err)
	);

	// 16-bit Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// byte address inside the preloaded region, low bits random too
	function automatic logic [31:0] rand_word_addr();
		logic [31:0] w;
		logic [31:0] lo;
		w = rand_bits(8) % FILL_WORDS;
		lo = rand_bits(2);
		return (w << 2) | lo;
	endfunction

	// store rule, only strobed bytes of an in-range word change
	function automatic void apply_store(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] idx;
		idx = {2'b00, addr[31:2]};
		if (idx < MEM_WORDS) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					shadow[idx[IDX_W-1:0]][b*8 +: 8] = data[b*8 +: 8];
				end
			end
		end
	endfunction

	// expected word index, data, error and last for one beat of an operation
	function automatic void expected_beat(input fsm_pkg::req_op_t op,
		input logic [31:0] addr, input logic [7:0] len, input int beat,
		output logic [31:0] idx, output logic [31:0] data, output logic err,
		output logic last);
		logic [31:0] start;
		logic [31:0] base;
		start = {2'b00, addr[31:2]};
		case (op)
			fsm_pkg::op_store: begin
				idx = start;
				last = 1'b1;
			end
			fsm_pkg::op_line: begin
				// aligned line, walk up from the start word and wrap to base
				base = start - (start % LINE_WORDS);
				idx = base + ((start + beat) % LINE_WORDS);
				last = (beat == LINE_WORDS - 1);
			end
			default: begin
				idx = start + beat;
				last = (beat == int'(len));
			end
		endcase
		err = (idx >= MEM_WORDS);
		if (err || op == fsm_pkg::op_store) begin
			data = '0;
		end else begin
			data = shadow[idx[IDX_W-1:0]];
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	// one request, returns once its last beat has been taken
	task automatic run_op(input fsm_pkg::req_op_t op, input logic [31:0] addr,
		input logic [7:0] len, input logic [31:0] wdata, input logic [3:0] wstrb);
		cur_op = op;
		cur_addr = addr;
		cur_len = len;
		if (op == fsm_pkg::op_store) begin
			apply_store(addr, wdata, wstrb);
		end
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_len = len;
		req_wdata = wdata;
		req_wstrb = wstrb;
		@(negedge clk);
		while (!req_ready) begin
			@(negedge clk);
		end
		// handshake on this edge
		@(posedge clk);
		#2;
		req_valid = 1'b0;
		ops_issued++;
		wait (ops_done == ops_issued);
		@(posedge clk);
		#2;
	endtask

	task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		run_op(fsm_pkg::op_store, addr, 8'd0, data, strb);
	endtask

	task automatic fetch_line(input logic [31:0] addr);
		run_op(fsm_pkg::op_line, addr, 8'd0, 32'd0, 4'h0);
	endtask

	task automatic read_stream(input logic [31:0] addr, input logic [7:0] len);
		run_op(fsm_pkg::op_stream, addr, len, 32'd0, 4'h0);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// beat_ready, random only while back-pressure is on
	initial begin
		logic bp_now;
		ready_lfsr = 16'd30;
		beat_ready = 1'b0;
		forever begin
			@(posedge clk);
			// back-pressure mode as it stood at the edge
			bp_now = bp_on;
			#2;
			if (bp_now) begin
				ready_lfsr = lfsr_step(ready_lfsr);
				beat_ready = ready_lfsr[0];
			end else begin
				beat_ready = 1'b1;
			end
		end
	end

	// sampled mid-cycle, a beat seen here is taken on the next rising edge
	always @(negedge clk) begin
		if (!rst) begin
			// idle until the first request goes in
			if (ops_issued == 0) begin
				check_value("req_ready", 32'd1, 32'(req_ready));
				check_value("beat_valid", 32'd0, 32'(beat_valid));
			end
			if (beat_valid && beat_ready) begin
				if (ops_done == ops_issued) begin
					errors++;
					$display("a beat came back with no operation in flight at %0t", $time);
				end else begin
					expected_beat(cur_op, cur_addr, cur_len, beat_no,
						exp_idx, exp_data, exp_err, exp_last);
					check_value($sformatf("beat_data word %h", exp_idx), exp_data,
						beat_data);
					check_value("beat_err", 32'(exp_err), 32'(beat_err));
					check_value("beat_last", 32'(exp_last), 32'(beat_last));
					beat_no++;
					if (beat_last) begin
						beat_no = 0;
						ops_done++;
					end
				end
			end
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0]  s;
		logic [7:0]  n;
		int          off;
		int          kind;
		stim_lfsr = 16'd30;
		rst = 1'b1;
		req_valid = 1'b0;
		req_op = fsm_pkg::op_line;
		req_addr = '0;
		req_len = '0;
		req_wdata = '0;
		req_wstrb = '0;
		cur_op = fsm_pkg::op_line;
		cur_addr = '0;
		cur_len = '0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		// idle window checked by the monitor
		repeat (4) @(posedge clk);
		#2;
		// preload with full-word stores
		for (int i = 0; i < FILL_WORDS; i++) begin
			d = rand_bits(32);
			store_word(i * 4, d, 4'hf);
		end
		// strobed stores, each read back
		for (int i = 0; i < N_STORE; i++) begin
			a = rand_word_addr();
			d = rand_bits(32);
			s = 4'(rand_bits(4));
			store_word(a, d, s);
			read_stream(a, 8'd0);
		end
		for (int i = 0; i < N_LINE; i++) begin
			a = rand_word_addr();
			fetch_line(a);
		end
		// lengths up to 32 words, most cross a line boundary
		for (int i = 0; i < N_STREAM; i++) begin
			n = 8'(rand_bits(5));
			a = (rand_bits(8) % (FILL_WORDS - n)) << 2;
			read_stream(a, n);
		end
		read_stream(32'h0, 8'hff);
		// out of range, first round right at the array end
		for (int i = 0; i < N_OOB; i++) begin
			off = (i == 0) ? 0 : int'(rand_bits(8));
			a = (MEM_WORDS + off) * 4;
			d = rand_bits(32);
			store_word(a, d, 4'hf);
			read_stream(a, 8'd3);
			fetch_line(a);
			// low word the store would alias onto
			read_stream(off * 4, 8'd0);
		end
		// random mix under back-pressure
		bp_on = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			kind = int'(rand_bits(2));
			if (kind == 0) begin
				a = rand_word_addr();
				d = rand_bits(32);
				s = 4'(rand_bits(4));
				store_word(a, d, s);
			end else if (kind == 1) begin
				a = rand_word_addr();
				fetch_line(a);
			end else begin
				n = 8'(rand_bits(5));
				a = (rand_bits(8) % (FILL_WORDS - n)) << 2;
				read_stream(a, n);
			end
		end
		bp_on = 1'b0;
		repeat (4) @(posedge clk);
		$display("operations %0d checks %0d errors %0d", ops_done, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog, sized for every operation at the longest burst
	initial begin
		repeat (LIMIT_CYCLES + 20) @(posedge clk);
		$display("the run timed out after %0d cycles with %0d of %0d operations done",
			LIMIT_CYCLES + 20, ops_done, N_OPS);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
